// ==== pu_riscv_pkg.sv ====
/*
 * Shared widths, opcodes and pipeline record types for the RV32I core.
 * Every unit refers to these by scoped name.
 */

package pu_riscv_pkg;

  //////////////////////////////
  // Widths and reset values

  localparam int XLEN    = 32;
  localparam int AR_BITS = 5;
  localparam int REG_CNT = 32;

  localparam logic [XLEN-1:0] PC_INIT   = 32'h0000_0200;
  // addi x0, x0, 0
  localparam logic [31:0]     INSTR_NOP = 32'h0000_0013;

  //////////////////////////////
  // Major opcodes

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB
  } alu_op_t;

  //////////////////////////////
  // Stage records

  // Decode to execute
  typedef struct packed {
    logic               valid;
    logic [XLEN-1:0]    pc;
    alu_op_t            alu_op;
    logic [XLEN-1:0]    opa;
    logic [XLEN-1:0]    opb;
    logic [XLEN-1:0]    std;
    logic [AR_BITS-1:0] rs1;
    logic [AR_BITS-1:0] rs2;
    logic [AR_BITS-1:0] rd;
    logic               we;
    logic               is_load;
    logic               is_store;
    logic               is_branch;
    logic               bne;
    logic               is_jal;
    logic [XLEN-1:0]    offset;
  } id_ex_t;

  // Execute to write-back
  typedef struct packed {
    logic               valid;
    logic [AR_BITS-1:0] rd;
    logic               we;
    logic               is_load;
    logic               is_store;
    logic [XLEN-1:0]    res;
    logic [XLEN-1:0]    std;
  } ex_wb_t;

endpackage

// ==== pu_riscv_rf_if.sv ====
/*
 * Register-file read path. Decode presents two source addresses and
 * the register file answers combinationally in the same cycle.
 */

`timescale 1ns/1ps

interface pu_riscv_rf_if;

  logic [pu_riscv_pkg::AR_BITS-1:0] rs1_addr;
  logic [pu_riscv_pkg::AR_BITS-1:0] rs2_addr;
  logic [pu_riscv_pkg::XLEN-1:0]    rs1_data;
  logic [pu_riscv_pkg::XLEN-1:0]    rs2_data;

  modport dec (
    output rs1_addr,
    output rs2_addr,
    input  rs1_data,
    input  rs2_data
  );

  modport rf (
    input  rs1_addr,
    input  rs2_addr,
    output rs1_data,
    output rs2_data
  );

endinterface

// ==== pu_riscv_if.sv ====
/*
 * Fetch unit. Drives the instruction memory address and pairs each
 * returning word with its pc. Under stall the word is held locally.
 */

`timescale 1ns/1ps

module pu_riscv_if (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          wb_stall_i,
  input  logic                          bu_flush_i,
  input  logic [pu_riscv_pkg::XLEN-1:0] bu_nxt_pc_i,
  input  logic [31:0]                   if_parcel_i,
  output logic [pu_riscv_pkg::XLEN-1:0] if_nxt_pc_o,
  output logic [pu_riscv_pkg::XLEN-1:0] if_pc_o,
  output logic [31:0]                   if_instr_o,
  output logic                          if_valid_o
);

  logic [pu_riscv_pkg::XLEN-1:0] nxt_pc_q;
  logic [pu_riscv_pkg::XLEN-1:0] pc_q;
  logic                          valid_q;
  logic                          hold_q;
  logic [31:0]                   instr_q;

  // Address of the word in flight and of the word now returning
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      nxt_pc_q <= pu_riscv_pkg::PC_INIT;
      pc_q     <= pu_riscv_pkg::PC_INIT;
      valid_q  <= 1'b0;
      hold_q   <= 1'b0;
    end else if (bu_flush_i) begin
      nxt_pc_q <= bu_nxt_pc_i;
      valid_q  <= 1'b0;
      hold_q   <= 1'b0;
    end else if (!wb_stall_i) begin
      nxt_pc_q <= nxt_pc_q + 32'd4;
      pc_q     <= nxt_pc_q;
      valid_q  <= 1'b1;
      hold_q   <= 1'b0;
    end else begin
      hold_q   <= 1'b1;
    end
  end

  // Memory already moved on to the next word, keep the current one
  always_ff @(posedge clk) begin
    if (wb_stall_i && !hold_q) begin
      instr_q <= if_parcel_i;
    end
  end

  assign if_nxt_pc_o = nxt_pc_q;
  assign if_pc_o     = pc_q;
  assign if_instr_o  = hold_q ? instr_q : if_parcel_i;
  assign if_valid_o  = valid_q;

endmodule

// ==== pu_riscv_id.sv ====
/*
 * Decode unit. Decodes the supported RV32I subset, reads both source
 * registers and registers the decoded instruction for execute.
 */

`timescale 1ns/1ps

module pu_riscv_id (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          wb_stall_i,
  input  logic                          bu_flush_i,
  input  logic [pu_riscv_pkg::XLEN-1:0] if_pc_i,
  input  logic [31:0]                   if_instr_i,
  input  logic                          if_valid_i,
  pu_riscv_rf_if.dec                    rf,
  output pu_riscv_pkg::id_ex_t          id_ex_o
);

  logic [31:0]                   instr;
  logic [2:0]                    funct3;
  logic [pu_riscv_pkg::XLEN-1:0] imm_i;
  logic [pu_riscv_pkg::XLEN-1:0] imm_s;
  logic [pu_riscv_pkg::XLEN-1:0] imm_b;
  logic [pu_riscv_pkg::XLEN-1:0] imm_u;
  logic [pu_riscv_pkg::XLEN-1:0] imm_j;
  logic                          known;
  pu_riscv_pkg::id_ex_t          id_ex_d;

  // Bubbles decode as a NOP so no stray register is named
  assign instr  = if_valid_i ? if_instr_i : pu_riscv_pkg::INSTR_NOP;
  assign funct3 = instr[14:12];

  assign rf.rs1_addr = instr[19:15];
  assign rf.rs2_addr = instr[24:20];

  //////////////////////////////
  // Immediates

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Unused source fields are zeroed so execute never forwards into them
  always_comb begin
    id_ex_d        = '0;
    id_ex_d.pc     = if_pc_i;
    id_ex_d.alu_op = pu_riscv_pkg::ALU_ADD;
    id_ex_d.opa    = rf.rs1_data;
    id_ex_d.opb    = rf.rs2_data;
    id_ex_d.std    = rf.rs2_data;
    id_ex_d.rs1    = instr[19:15];
    id_ex_d.rs2    = instr[24:20];
    id_ex_d.rd     = instr[11:7];
    known          = 1'b1;
    case (instr[6:0])
      pu_riscv_pkg::OPC_OP: begin
        id_ex_d.we = 1'b1;
        case (funct3)
          3'b000:  id_ex_d.alu_op = instr[30] ? pu_riscv_pkg::ALU_SUB : pu_riscv_pkg::ALU_ADD;
          3'b010:  id_ex_d.alu_op = pu_riscv_pkg::ALU_SLT;
          3'b100:  id_ex_d.alu_op = pu_riscv_pkg::ALU_XOR;
          3'b110:  id_ex_d.alu_op = pu_riscv_pkg::ALU_OR;
          3'b111:  id_ex_d.alu_op = pu_riscv_pkg::ALU_AND;
          default: known = 1'b0;
        endcase
      end
      pu_riscv_pkg::OPC_OP_IMM: begin
        known       = (funct3 == 3'b000);
        id_ex_d.we  = 1'b1;
        id_ex_d.opb = imm_i;
        id_ex_d.rs2 = '0;
      end
      pu_riscv_pkg::OPC_LUI: begin
        id_ex_d.we     = 1'b1;
        id_ex_d.alu_op = pu_riscv_pkg::ALU_PASSB;
        id_ex_d.opb    = imm_u;
        id_ex_d.rs1    = '0;
        id_ex_d.rs2    = '0;
      end
      pu_riscv_pkg::OPC_BRANCH: begin
        known             = (funct3[2:1] == 2'b00);
        id_ex_d.is_branch = 1'b1;
        id_ex_d.bne       = funct3[0];
        id_ex_d.offset    = imm_b;
        id_ex_d.rd        = '0;
      end
      pu_riscv_pkg::OPC_JAL: begin
        id_ex_d.we     = 1'b1;
        id_ex_d.is_jal = 1'b1;
        id_ex_d.offset = imm_j;
        id_ex_d.rs1    = '0;
        id_ex_d.rs2    = '0;
      end
      pu_riscv_pkg::OPC_LOAD: begin
        known           = (funct3 == 3'b010);
        id_ex_d.we      = 1'b1;
        id_ex_d.is_load = 1'b1;
        id_ex_d.opb     = imm_i;
        id_ex_d.rs2     = '0;
      end
      pu_riscv_pkg::OPC_STORE: begin
        known            = (funct3 == 3'b010);
        id_ex_d.is_store = 1'b1;
        id_ex_d.opb      = imm_s;
        id_ex_d.rd       = '0;
      end
      default: known = 1'b0;
    endcase
    id_ex_d.valid = if_valid_i & known;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o <= '0;
    end else if (bu_flush_i) begin
      id_ex_o.valid <= 1'b0;
    end else if (!wb_stall_i) begin
      id_ex_o <= id_ex_d;
    end
  end

  // Neither wrong-path word may reach execute
  a_flush_kills: assert property (@(posedge clk) disable iff (!rst_n_i)
    bu_flush_i |=> !id_ex_o.valid ##1 !id_ex_o.valid);

endmodule

// ==== pu_riscv_execution.sv ====
/*
 * Execution unit. Applies forwarding from write-back, runs the ALU,
 * resolves BEQ, BNE and JAL and registers the result for write-back.
 */

`timescale 1ns/1ps

module pu_riscv_execution (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             wb_stall_i,
  input  pu_riscv_pkg::id_ex_t             id_ex_i,
  input  logic                             fwd_valid_i,
  input  logic [pu_riscv_pkg::AR_BITS-1:0] fwd_rd_i,
  input  logic [pu_riscv_pkg::XLEN-1:0]    fwd_value_i,
  output pu_riscv_pkg::ex_wb_t             ex_wb_o,
  output logic                             bu_flush_o,
  output logic [pu_riscv_pkg::XLEN-1:0]    bu_nxt_pc_o
);

  logic                          fwd_live;
  logic                          hit1;
  logic                          hit2;
  logic [pu_riscv_pkg::XLEN-1:0] opa;
  logic [pu_riscv_pkg::XLEN-1:0] opb;
  logic [pu_riscv_pkg::XLEN-1:0] std;
  logic [pu_riscv_pkg::XLEN-1:0] alu_r;
  logic                          taken;
  pu_riscv_pkg::ex_wb_t          ex_wb_d;

  //////////////////////////////
  // Operand forwarding

  assign fwd_live = fwd_valid_i && (fwd_rd_i != '0);
  assign hit1     = fwd_live && (fwd_rd_i == id_ex_i.rs1);
  assign hit2     = fwd_live && (fwd_rd_i == id_ex_i.rs2);

  assign opa = hit1 ? fwd_value_i : id_ex_i.opa;
  // Store operand B is the offset, rs2 goes to the data path only
  assign opb = (hit2 && !id_ex_i.is_store) ? fwd_value_i : id_ex_i.opb;
  assign std = hit2 ? fwd_value_i : id_ex_i.std;

  always_comb begin
    case (id_ex_i.alu_op)
      pu_riscv_pkg::ALU_SUB:   alu_r = opa - opb;
      pu_riscv_pkg::ALU_AND:   alu_r = opa & opb;
      pu_riscv_pkg::ALU_OR:    alu_r = opa | opb;
      pu_riscv_pkg::ALU_XOR:   alu_r = opa ^ opb;
      pu_riscv_pkg::ALU_SLT:   alu_r = {31'b0, $signed(opa) < $signed(opb)};
      pu_riscv_pkg::ALU_PASSB: alu_r = opb;
      default:                 alu_r = opa + opb;
    endcase
  end

  //////////////////////////////
  // Branch unit

  assign taken = id_ex_i.is_jal ||
                 (id_ex_i.is_branch && ((opa == opb) ^ id_ex_i.bne));

  // Waits while write-back is frozen, the branch stays in place
  assign bu_flush_o  = id_ex_i.valid && taken && !wb_stall_i;
  assign bu_nxt_pc_o = id_ex_i.pc + id_ex_i.offset;

  always_comb begin
    ex_wb_d.valid    = id_ex_i.valid;
    ex_wb_d.rd       = id_ex_i.rd;
    ex_wb_d.we       = id_ex_i.we;
    ex_wb_d.is_load  = id_ex_i.is_load;
    ex_wb_d.is_store = id_ex_i.is_store;
    ex_wb_d.res      = id_ex_i.is_jal ? id_ex_i.pc + 32'd4 : alu_r;
    ex_wb_d.std      = std;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_wb_o <= '0;
    end else if (!wb_stall_i) begin
      ex_wb_o <= ex_wb_d;
    end
  end

  // Redirect is a single pulse outside any stall
  a_flush_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    bu_flush_o |-> !wb_stall_i ##1 !bu_flush_o);

endmodule

// ==== pu_riscv_wb.sv ====
/*
 * Write-back unit. Issues loads and stores on the data bus, freezes
 * the pipeline until acknowledge and writes results to the register file.
 */

`timescale 1ns/1ps

module pu_riscv_wb (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  pu_riscv_pkg::ex_wb_t             ex_wb_i,
  input  logic                             dmem_ack_i,
  input  logic [pu_riscv_pkg::XLEN-1:0]    dmem_q_i,
  output logic                             dmem_req_o,
  output logic                             dmem_we_o,
  output logic [pu_riscv_pkg::XLEN-1:0]    dmem_adr_o,
  output logic [pu_riscv_pkg::XLEN-1:0]    dmem_d_o,
  output logic                             wb_stall_o,
  output logic                             rf_we_o,
  output logic [pu_riscv_pkg::AR_BITS-1:0] rf_dst_o,
  output logic [pu_riscv_pkg::XLEN-1:0]    rf_dstv_o,
  output logic                             fwd_valid_o,
  output logic [pu_riscv_pkg::AR_BITS-1:0] fwd_rd_o,
  output logic [pu_riscv_pkg::XLEN-1:0]    fwd_value_o
);

  logic mem_op;
  logic acked;
  logic done_q;

  assign mem_op = ex_wb_i.valid && (ex_wb_i.is_load || ex_wb_i.is_store);

  // Request drops for one cycle after each acknowledge
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= acked;
    end
  end

  assign dmem_req_o = mem_op && !done_q;
  assign dmem_we_o  = dmem_req_o && ex_wb_i.is_store;
  assign dmem_adr_o = ex_wb_i.res;
  assign dmem_d_o   = ex_wb_i.std;
  assign acked      = dmem_req_o && dmem_ack_i;
  assign wb_stall_o = mem_op && !acked;

  // ALU results now, load data on acknowledge
  assign rf_we_o   = ex_wb_i.valid && ex_wb_i.we && (!ex_wb_i.is_load || acked);
  assign rf_dst_o  = ex_wb_i.rd;
  assign rf_dstv_o = ex_wb_i.is_load ? dmem_q_i : ex_wb_i.res;

  assign fwd_valid_o = rf_we_o;
  assign fwd_rd_o    = rf_dst_o;
  assign fwd_value_o = rf_dstv_o;

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    dmem_req_o && !dmem_ack_i |=> dmem_req_o && $stable(dmem_adr_o) && $stable(dmem_d_o));

endmodule

// ==== pu_riscv_rf.sv ====
/*
 * Integer register file, two read ports and one write port.
 * x0 reads as zero and a same-cycle write is visible to the readers.
 */

`timescale 1ns/1ps

module pu_riscv_rf (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             rf_we_i,
  input  logic [pu_riscv_pkg::AR_BITS-1:0] rf_dst_i,
  input  logic [pu_riscv_pkg::XLEN-1:0]    rf_dstv_i,
  pu_riscv_rf_if.rf                        rd
);

  logic [pu_riscv_pkg::XLEN-1:0] regs [1:pu_riscv_pkg::REG_CNT-1];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < pu_riscv_pkg::REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we_i && rf_dst_i != '0) begin
      regs[rf_dst_i] <= rf_dstv_i;
    end
  end

  // Write-through bypass
  assign rd.rs1_data = (rd.rs1_addr == '0) ? '0 :
                       (rf_we_i && rf_dst_i == rd.rs1_addr) ? rf_dstv_i : regs[rd.rs1_addr];
  assign rd.rs2_data = (rd.rs2_addr == '0) ? '0 :
                       (rf_we_i && rf_dst_i == rd.rs2_addr) ? rf_dstv_i : regs[rd.rs2_addr];

endmodule

// ==== pu_riscv_core.sv ====
/*
 * Four-stage RV32I core. Connects fetch, decode, execution, write-back
 * and the register file to the instruction and data memory ports.
 */

`timescale 1ns/1ps

module pu_riscv_core (
  input  logic                          clk,
  input  logic                          rst_n_i,
  output logic [pu_riscv_pkg::XLEN-1:0] if_nxt_pc_o,
  input  logic [31:0]                   if_parcel_i,
  output logic                          dmem_req_o,
  output logic                          dmem_we_o,
  output logic [pu_riscv_pkg::XLEN-1:0] dmem_adr_o,
  output logic [pu_riscv_pkg::XLEN-1:0] dmem_d_o,
  input  logic                          dmem_ack_i,
  input  logic [pu_riscv_pkg::XLEN-1:0] dmem_q_i
);

  //////////////////////////////
  // Pipeline wiring

  logic [pu_riscv_pkg::XLEN-1:0]    if_pc;
  logic [31:0]                      if_instr;
  logic                             if_valid;
  logic                             bu_flush;
  logic [pu_riscv_pkg::XLEN-1:0]    bu_nxt_pc;
  logic                             wb_stall;
  pu_riscv_pkg::id_ex_t             id_ex;
  pu_riscv_pkg::ex_wb_t             ex_wb;
  logic                             fwd_valid;
  logic [pu_riscv_pkg::AR_BITS-1:0] fwd_rd;
  logic [pu_riscv_pkg::XLEN-1:0]    fwd_value;
  logic                             rf_we;
  logic [pu_riscv_pkg::AR_BITS-1:0] rf_dst;
  logic [pu_riscv_pkg::XLEN-1:0]    rf_dstv;

  pu_riscv_rf_if rf_bus ();

  pu_riscv_if if_unit (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wb_stall_i (wb_stall),
    .bu_flush_i (bu_flush),
    .bu_nxt_pc_i(bu_nxt_pc),
    .if_parcel_i(if_parcel_i),
    .if_nxt_pc_o(if_nxt_pc_o),
    .if_pc_o    (if_pc),
    .if_instr_o (if_instr),
    .if_valid_o (if_valid)
  );

  pu_riscv_id id_unit (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wb_stall_i(wb_stall),
    .bu_flush_i(bu_flush),
    .if_pc_i   (if_pc),
    .if_instr_i(if_instr),
    .if_valid_i(if_valid),
    .rf        (rf_bus.dec),
    .id_ex_o   (id_ex)
  );

  pu_riscv_execution execution_unit (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wb_stall_i (wb_stall),
    .id_ex_i    (id_ex),
    .fwd_valid_i(fwd_valid),
    .fwd_rd_i   (fwd_rd),
    .fwd_value_i(fwd_value),
    .ex_wb_o    (ex_wb),
    .bu_flush_o (bu_flush),
    .bu_nxt_pc_o(bu_nxt_pc)
  );

  pu_riscv_wb wb_unit (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ex_wb_i    (ex_wb),
    .dmem_ack_i (dmem_ack_i),
    .dmem_q_i   (dmem_q_i),
    .dmem_req_o (dmem_req_o),
    .dmem_we_o  (dmem_we_o),
    .dmem_adr_o (dmem_adr_o),
    .dmem_d_o   (dmem_d_o),
    .wb_stall_o (wb_stall),
    .rf_we_o    (rf_we),
    .rf_dst_o   (rf_dst),
    .rf_dstv_o  (rf_dstv),
    .fwd_valid_o(fwd_valid),
    .fwd_rd_o   (fwd_rd),
    .fwd_value_o(fwd_value)
  );

  pu_riscv_rf rf_unit (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .rf_we_i  (rf_we),
    .rf_dst_i (rf_dst),
    .rf_dstv_i(rf_dstv),
    .rd       (rf_bus.rf)
  );

endmodule

// ==== tb_programs.svh ====
/*
 * Stimulus table for the core testbench. Each entry lists a program as
 * encoded instructions from PC_INIT and the stores it must produce.
 */

localparam int NUM_PROGRAMS = 4;

// Each program gives its instruction words and then its expected stores
task automatic build_program(input int p);
  case (p)
    // ALU results, dependent back to back, write to x0
    0: begin
      emit(enc_i(25, 0, 0, 1, 7'h13));
      emit(enc_i(-7, 0, 0, 2, 7'h13));
      emit(enc_r(7'h00, 2, 1, 0, 3));
      emit(enc_r(7'h20, 2, 1, 0, 4));
      emit(enc_r(7'h00, 2, 1, 7, 5));
      emit(enc_r(7'h00, 2, 1, 6, 6));
      emit(enc_r(7'h00, 2, 1, 4, 7));
      emit(enc_r(7'h00, 1, 2, 2, 8));
      emit(enc_r(7'h00, 2, 1, 2, 9));
      emit(enc_lui(10, 20'h12345));
      for (int r = 3; r <= 10; r++) begin
        emit(enc_sw(r, 0, 32'h100 + 4 * (r - 3)));
      end
      // x0 written right before it is stored
      emit(enc_i(5, 0, 0, 0, 7'h13));
      emit(enc_sw(0, 0, 32'h120));
      emit(enc_jal(0, 0));
      expect_store(32'h100, 32'd25 + 32'hffff_fff9);
      expect_store(32'h104, 32'd25 - 32'hffff_fff9);
      expect_store(32'h108, 32'd25 & 32'hffff_fff9);
      expect_store(32'h10c, 32'd25 | 32'hffff_fff9);
      expect_store(32'h110, 32'd25 ^ 32'hffff_fff9);
      expect_store(32'h114, 32'd1);
      expect_store(32'h118, 32'd0);
      expect_store(32'h11c, 32'h1234_5000);
      expect_store(32'h120, 32'd0);
    end
    // Forwarding and load followed by use
    1: begin
      emit(enc_i(3, 0, 0, 1, 7'h13));
      emit(enc_i(4, 1, 0, 1, 7'h13));
      emit(enc_r(7'h00, 1, 1, 0, 2));
      emit(enc_sw(2, 0, 32'h100));
      emit(enc_i(32'h100, 0, 2, 3, 7'h03));
      emit(enc_i(1, 3, 0, 4, 7'h13));
      emit(enc_sw(4, 0, 32'h104));
      emit(enc_i(32'h140, 0, 2, 5, 7'h03));
      emit(enc_r(7'h00, 5, 5, 0, 6));
      emit(enc_sw(6, 0, 32'h108));
      emit(enc_sw(5, 0, 32'h10c));
      emit(enc_jal(0, 0));
      expect_store(32'h100, 32'd14);
      expect_store(32'h104, 32'd15);
      expect_store(32'h108, fill_word(32'h140) * 2);
      expect_store(32'h10c, fill_word(32'h140));
    end
    // Branches and JAL, skipped stores must not appear
    2: begin
      emit(enc_i(5, 0, 0, 1, 7'h13));
      emit(enc_i(5, 0, 0, 2, 7'h13));
      emit(enc_br(0, 1, 2, 12));
      emit(enc_sw(1, 0, 32'h100));
      emit(enc_sw(1, 0, 32'h104));
      emit(enc_br(1, 1, 2, 8));
      emit(enc_sw(2, 0, 32'h108));
      emit(enc_i(6, 0, 0, 2, 7'h13));
      emit(enc_br(1, 1, 2, 8));
      emit(enc_sw(2, 0, 32'h10c));
      emit(enc_br(0, 1, 2, 8));
      emit(enc_sw(2, 0, 32'h110));
      emit(enc_jal(7, 8));
      emit(enc_sw(2, 0, 32'h114));
      emit(enc_sw(7, 0, 32'h118));
      emit(enc_jal(0, 0));
      expect_store(32'h108, 32'd5);
      expect_store(32'h110, 32'd6);
      // JAL sits at word 12 of the program
      expect_store(32'h118, pu_riscv_pkg::PC_INIT + 4 * 12 + 4);
    end
    // Store and load round trip under random acknowledge latency
    3: begin
      for (int i = 0; i < 8; i++) begin
        emit(enc_i(i * 11 + 3, 0, 0, 1, 7'h13));
        emit(enc_sw(1, 0, 32'h180 + 4 * i));
        expect_store(32'h180 + 4 * i, i * 11 + 3);
      end
      emit(enc_i(32'h180, 0, 2, 2, 7'h03));
      emit(enc_i(32'h184, 0, 2, 3, 7'h03));
      emit(enc_r(7'h00, 3, 2, 0, 4));
      emit(enc_sw(4, 0, 32'h1a0));
      emit(enc_jal(0, 0));
      expect_store(32'h1a0, 32'd3 + 32'd14);
    end
    default: begin
      emit(enc_jal(0, 0));
    end
  endcase
endtask

// ==== tb_pu_riscv_core.sv ====
/*
 * Testbench for the RV32I core. Runs each program of the stimulus table
 * against instruction and data memory models and compares the stores.
 */

`timescale 1ns/1ps

module tb_pu_riscv_core;

  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 256;

  // Architectural reset address
  localparam logic [31:0] RESET_PC = 32'h0000_0200;

  logic        clk;
  logic        rst_n_i;
  logic [31:0] if_nxt_pc_o;
  logic [31:0] if_parcel_i;
  logic        dmem_req_o;
  logic        dmem_we_o;
  logic [31:0] dmem_adr_o;
  logic [31:0] dmem_d_o;
  logic        dmem_ack_i;
  logic [31:0] dmem_q_i;

  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  int          prog_len;
  logic [31:0] exp_adr [$];
  logic [31:0] exp_dat [$];
  logic [31:0] log_adr [$];
  logic [31:0] log_dat [$];
  logic [31:0] prev_addr;
  logic [31:0] prev_nxt;
  logic [31:0] end_pc;
  int          end_hits;
  logic        pending;
  int unsigned lat_left;
  int          errors;
  int          checks;

  pu_riscv_core i_pu_riscv_core (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .if_nxt_pc_o(if_nxt_pc_o),
    .if_parcel_i(if_parcel_i),
    .dmem_req_o (dmem_req_o),
    .dmem_we_o  (dmem_we_o),
    .dmem_adr_o (dmem_adr_o),
    .dmem_d_o   (dmem_d_o),
    .dmem_ack_i (dmem_ack_i),
    .dmem_q_i   (dmem_q_i)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // Instruction encoders

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                        input int rd, input logic [6:0] opc);
    logic [11:0] im;
    im = imm[11:0];
    return {im, rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_sw(input int rs2, input int rs1, input int imm);
    logic [11:0] im;
    im = imm[11:0];
    return {im[11:5], rs2[4:0], rs1[4:0], 3'b010, im[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_br(input int f3, input int rs1, input int rs2,
                                         input int off);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2[4:0], rs1[4:0], f3[2:0], o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input int rd, input int off);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] imm);
    return {imm, rd[4:0], 7'b0110111};
  endfunction

  // Background data memory contents
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
    exp_adr.push_back(a);
    exp_dat.push_back(d);
  endtask

  `include "tb_programs.svh"

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  //////////////////////////////
  // Memory models driven on the falling edge

  always @(negedge clk) begin
    logic [31:0] idx;
    idx = (prev_addr - pu_riscv_pkg::PC_INIT) >> 2;
    if (prev_addr >= pu_riscv_pkg::PC_INIT && idx < IMEM_WORDS) begin
      if_parcel_i <= imem[idx];
    end else begin
      if_parcel_i <= pu_riscv_pkg::INSTR_NOP;
    end
    prev_addr = if_nxt_pc_o;

    if (dmem_ack_i) begin
      dmem_ack_i <= 1'b0;
      pending = 1'b0;
    end else if (dmem_req_o) begin
      if (!pending) begin
        pending  = 1'b1;
        lat_left = $urandom % 4;
      end
      if (lat_left == 0) begin
        dmem_ack_i <= 1'b1;
        if (dmem_we_o) begin
          dmem[dmem_adr_o[9:2]] = dmem_d_o;
          log_adr.push_back(dmem_adr_o);
          log_dat.push_back(dmem_d_o);
        end else begin
          dmem_q_i <= dmem[dmem_adr_o[9:2]];
        end
      end else begin
        lat_left--;
      end
    end

    // The end marker brings the fetch address back to itself
    if (if_nxt_pc_o == end_pc && prev_nxt != end_pc) begin
      end_hits++;
    end
    prev_nxt = if_nxt_pc_o;
  end

  // Watchdog
  initial begin
    repeat (200 * NUM_PROGRAMS + 10 * NUM_PROGRAMS) @(posedge clk);
    $display("Run timed out before all programs reached their end marker");
    $display("tests failed");
    $finish;
  end

  initial begin
    int unsigned seed_val;
    seed_val    = $urandom(32'h22257d57);
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    if_parcel_i = pu_riscv_pkg::INSTR_NOP;
    dmem_ack_i  = 1'b0;
    dmem_q_i    = '0;
    prev_addr   = '0;
    prev_nxt    = '0;
    end_pc      = '1;
    end_hits    = 0;
    pending     = 1'b0;
    lat_left    = 0;
    errors      = 0;
    checks      = 0;

    for (int p = 0; p < NUM_PROGRAMS; p++) begin
      @(negedge clk);
      rst_n_i = 1'b0;
      for (int i = 0; i < IMEM_WORDS; i++) begin
        imem[i] = pu_riscv_pkg::INSTR_NOP;
      end
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] = fill_word(i * 4);
      end
      prog_len = 0;
      exp_adr.delete();
      exp_dat.delete();
      log_adr.delete();
      log_dat.delete();
      build_program(p);
      end_pc   = pu_riscv_pkg::PC_INIT + 4 * (prog_len - 1);
      end_hits = 0;
      prev_nxt = '0;
      pending  = 1'b0;
      repeat (5) @(negedge clk);
      rst_n_i = 1'b1;

      // State straight after reset
      check(if_nxt_pc_o, RESET_PC, "fetch address after reset");
      check({31'b0, dmem_req_o}, 32'd0, "data request after reset");

      while (end_hits < 2) begin
        @(negedge clk);
      end
      repeat (4) @(negedge clk);

      check(log_adr.size(), exp_adr.size(), $sformatf("program %0d store count", p));
      for (int i = 0; i < exp_adr.size() && i < log_adr.size(); i++) begin
        check(log_adr[i], exp_adr[i], $sformatf("program %0d store %0d address", p, i));
        check(log_dat[i], exp_dat[i], $sformatf("program %0d store %0d data", p, i));
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
pu_riscv_pkg.sv
pu_riscv_rf_if.sv
pu_riscv_if.sv
pu_riscv_id.sv
pu_riscv_execution.sv
pu_riscv_wb.sv
pu_riscv_rf.sv
pu_riscv_core.sv
tb_pu_riscv_core.sv
